/* isr_decoder.f */
+incdir+.
isr_decoder_pkg.sv
isr_field_decode.sv
reg_port_decode.sv
alu_ctl_decode.sv
bus_ctl_decode.sv
isr_decoder.sv
tb_isr_decoder.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_isr_decoder
FILELIST  = isr_decoder.f

SRCS = $(filter-out +%,$(shell cat $(FILELIST))) isr_decoder_defs.svh
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_isr_decoder.sv */
`timescale 1ns/100ps
`include "isr_decoder_defs.svh"

module tb_isr_decoder;
    localparam int DIRECTED = 472; // strobes in the directed tests
    localparam int RANDOM   = 2000;
    localparam int LIMIT    = 3 + 2 * DIRECTED + 4 * RANDOM + 50;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        isr_valid = 1'b0;
    logic [15:0] isr = '0;
    logic [10:0] phase = '0;
    logic [3:0]  flags = '0;  // n z v c
    wire         ctl_valid;
    wire  [37:0] act;         // all control outputs, r_addr first
    logic        vld_q;
    logic [37:0] exp_q;
    string       test_name = "reset";
    string       name_q = "reset";
    int          value_errors = 0;
    int          valid_errors = 0;
    int          cycles = 0;
    int          rd_ph[4] = '{`PH_FF0, `PH_FF1, `PH_TF0, `PH_TF1};
    int          ex_ph[4] = '{`PH_IF1, `PH_EX1, `PH_IT1, `PH_IT2};
    logic [5:0]  pc_ops[6] = '{6'h11, 6'h12, 6'h13, 6'h2c, 6'h2d, 6'h2e};
    logic [5:0]  wb_ops[16] = '{6'h04, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e,
                                6'h0f, 6'h10, 6'h14, 6'h15, 6'h16, 6'h20, 6'h21, 6'h22};

    isr_decoder DUT (
        .clk(clk), .arst_n(arst_n), .isr_valid(isr_valid), .isr(isr), .phase(phase),
        .psw_n(flags[3]), .psw_z(flags[2]), .psw_v(flags[1]), .psw_c(flags[0]),
        .ctl_valid(ctl_valid), .r_addr(act[37:30]), .sr(act[29:22]),
        .mda(act[21]), .b0b(act[20]), .smd(act[19]), .sma(act[18]), .sb0(act[17]),
        .als(act[16]), .alu_x(act[15]), .alu_y(act[14]), .alu_z(act[13]),
        .alu_u(act[12]), .alu_v(act[11]), .shs(act[10]), .sft_a(act[9]),
        .sft_b(act[8]), .sft_c(act[7]), .sft_d(act[6]), .sft_e(act[5]), .sft_r(act[4]),
        .sft_l(act[3]), .set_psw(act[2]), .f_is_d(act[1]), .t_is_d(act[0])
    );

    always #4 clk = ~clk;

    function automatic logic [37:0] expected_ctl(input logic [15:0] w, input logic [10:0] ph,
                                                 input logic [3:0] fl);
        logic [5:0] o;
        logic [7:0] fr;
        logic [7:0] tr;
        logic [7:0] ra;
        logic [7:0] s;
        logic       f_ip;
        logic       sh;
        logic       rbx;
        logic       brx;
        logic       wb;
        logic       b0;
        logic       y;
        o    = w[15:10];
        fr   = 8'd1 << w[7:5];
        tr   = 8'd1 << w[2:0];
        f_ip = ph[`PH_FF0] | (ph[`PH_FF1] & (w[9:8] == 2'd3));
        sh   = o inside {[6'h08:6'h0f]};
        brx  = o inside {[6'h30:6'h33]};
        rbx  = o inside {[6'h38:6'h3b]};
        wb   = sh | (o inside {6'h04, 6'h10, 6'h14, 6'h15, 6'h16, 6'h20, 6'h21, 6'h22});
        b0   = brx | rbx | (o inside {6'h10, 6'h11, 6'h14, 6'h15, 6'h16, 6'h18, 6'h1a, 6'h1b,
                                      6'h20, 6'h21, 6'h22, 6'h23, 6'h2c, 6'h2d, 6'h2e});
        y    = ph[`PH_IF0] | ph[`PH_IF1] | ph[`PH_FF0] | ph[`PH_FF2] | ph[`PH_TF0] |
               ph[`PH_TF1] | ph[`PH_EX1] | ph[`PH_IT0] | ph[`PH_IT1] | brx |
               (o inside {6'h10, 6'h11, 6'h12, 6'h13, 6'h14, 6'h15, 6'h16, 6'h18, 6'h1a,
                          6'h1b, 6'h2c, 6'h2d, 6'h2e});
        ra = ({8{f_ip}} & fr) | ({8{ph[`PH_TF0] | (ph[`PH_TF1] & (w[4:3] == 2'd3))}} & tr);
        ra[`SP_REG] |= (o inside {6'h12, 6'h13}) | ph[`PH_IT0] | ph[`PH_IT1];
        ra[`PC_REG] |= ph[`PH_IF0] | ph[`PH_IF1] | ((o == 6'h2d) & ph[`PH_EX1]);
        s = ({8{f_ip}} & fr) |
            ({8{(ph[`PH_TF1] & (w[4:3] == 2'd3)) | (wb & (w[4:3] == 2'd0))}} & tr);
        s[`SP_REG] |= ph[`PH_IT1];
        s[`PC_REG] |= ph[`PH_IF1] | ph[`PH_IT2] | (o inside {6'h11, 6'h12, 6'h13}) |
                      ((brx | rbx) & fl[~o[1:0]]) |  // low op bits pick n, z, v or c
                      (ph[`PH_EX1] & (o inside {6'h2c, 6'h2d, 6'h2e}));
        return {ra, s,
                ph[`PH_FF2] | sh | rbx | (o inside {6'h14, 6'h15, 6'h16, 6'h18, 6'h1a,
                                                    6'h1b, 6'h20, 6'h21, 6'h22, 6'h23}),
                ph[`PH_EX1] | b0,
                ph[`PH_IF0] | ph[`PH_FF0] | ph[`PH_TF0] | sh |
                (o inside {6'h04, 6'h10, 6'h14, 6'h15, 6'h16, 6'h18, 6'h1a, 6'h20, 6'h21,
                           6'h22, 6'h2c, 6'h2d, 6'h2e}),
                ph[`PH_IF0] | ph[`PH_FF0] | ph[`PH_TF0] | ph[`PH_IT0],
                ph[`PH_FF2],
                (|ph[`PH_IT1:`PH_IF0]) | b0 | (o inside {6'h04, 6'h12, 6'h13}),
                (ph[`PH_FF0] & (w[9:8] == 2'd2)) | (o inside {6'h18, 6'h1a, 6'h1b}),
                y,
                (o == 6'h20) | rbx,
                ph[`PH_IF1] | ph[`PH_TF1] | ph[`PH_IT1] | (o inside {6'h18, 6'h1b}) |
                (fl[0] & (o inside {6'h16, 6'h1a})),
                y | (o == 6'h21) | rbx,
                sh, o == 6'h09, o == 6'h0e, o inside {6'h0a, 6'h0d, 6'h0e}, o == 6'h0f,
                o inside {6'h0a, 6'h0b}, o inside {6'h09, 6'h0b, 6'h0f},
                o inside {6'h09, 6'h0a, 6'h0d, 6'h0e},
                sh | (o inside {6'h04, 6'h10, 6'h14, 6'h16, 6'h18, 6'h1a, 6'h1b, 6'h20,
                                6'h21, 6'h22, 6'h23}),
                w[9:8] == 2'd0, w[4:3] == 2'd0};
    endfunction

    // model of the latch, the result of the last strobe
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= 1'b0;
            exp_q <= expected_ctl('0, '0, '0);
        end else begin
            vld_q <= isr_valid;
            if (isr_valid) begin
                exp_q  <= expected_ctl(isr, phase, flags);
                name_q <= test_name;
            end
        end
    end

    always @(negedge clk) begin
        if (ctl_valid !== vld_q) begin
            valid_errors++;
            $display("error %s ctl_valid: expected %b actual %b", name_q, vld_q, ctl_valid);
        end
        if (act !== exp_q) begin
            value_errors++;
            $display("error %s: expected %h actual %h", name_q, exp_q, act);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: the tests did not end within %0d cycles", LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // one strobe, then gap idle cycles with changing inputs
    task automatic send(input logic [15:0] w, input logic [10:0] ph, input logic [3:0] fl,
                        input int gap);
        @(posedge clk);
        #1;
        isr_valid = 1'b1;
        isr       = w;
        phase     = ph;
        flags     = fl;
        repeat (gap) begin
            @(posedge clk);
            #1;
            isr_valid = 1'b0;
            isr       = 16'($urandom);
            phase     = 11'($urandom);
            flags     = 4'($urandom);
        end
    endtask

    initial begin
        void'($urandom(32'hac11a24c));
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_name = "read_sel";
        for (int p = 0; p < 4; p++)
            for (int m = 0; m < 4; m++)
                for (int r = 0; r < 8; r++)
                    send({6'h00, m[1:0], r[2:0], m[1:0], 3'(7 - r)}, 11'(1) << rd_ph[p],
                         4'($urandom), r & 1);
        test_name = "write_sel";
        for (int i = 0; i < 16; i++)
            for (int m = 0; m < 4; m++)
                send({wb_ops[i], 5'($urandom), m[1:0], 3'(i)}, '0, '0, m & 1);
        for (int i = 0; i < 6; i++)
            for (int j = 0; j < 4; j++)
                send({pc_ops[i], 10'($urandom)}, 11'(1) << ex_ph[j], 4'($urandom), j & 1);
        for (int b = 0; b < 8; b++)
            for (int f = 0; f < 16; f++)
                send({2'b11, b[2], 1'b0, b[1:0], 10'($urandom)}, '0, 4'(f), f & 1);
        test_name = "alu_ctl";
        for (int o = 0; o < 64; o++)
            for (int c = 0; c < 2; c++)
                send({6'(o), 10'($urandom)}, '0, {3'($urandom), c[0]}, c);
        test_name = "random";
        for (int i = 0; i < RANDOM; i++)
            send(16'($urandom), ($urandom & 1) ? 11'(1) << ($urandom % 12) : 11'($urandom),
                 4'($urandom), $urandom % 4);
        send(16'($urandom), 11'($urandom), 4'($urandom), 3);
        @(negedge clk);
        #1;
        $display("errors: %0d value, %0d valid", value_errors, valid_errors);
        if (value_errors + valid_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* isr_decoder.sv */
`timescale 1ns/100ps

module isr_decoder (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      isr_valid,
    input  isr_decoder_pkg::isr_t     isr,
    input  isr_decoder_pkg::phase_t   phase,
    input  logic                      psw_n,
    input  logic                      psw_z,
    input  logic                      psw_v,
    input  logic                      psw_c,
    output logic                      ctl_valid,
    output isr_decoder_pkg::reg_sel_t r_addr,
    output isr_decoder_pkg::reg_sel_t sr,
    output logic                      mda,
    output logic                      b0b,
    output logic                      smd,
    output logic                      sma,
    output logic                      sb0,
    output logic                      als,
    output logic                      alu_x,
    output logic                      alu_y,
    output logic                      alu_z,
    output logic                      alu_u,
    output logic                      alu_v,
    output logic                      shs,
    output logic                      sft_a,
    output logic                      sft_b,
    output logic                      sft_c,
    output logic                      sft_d,
    output logic                      sft_e,
    output logic                      sft_r,
    output logic                      sft_l,
    output logic                      set_psw,
    output logic                      f_is_d,
    output logic                      t_is_d
);
    import isr_decoder_pkg::*;

    ex_op_e     op;
    addr_mode_e f_mode;
    addr_mode_e t_mode;
    reg_sel_t   f_reg;
    reg_sel_t   t_reg;
    phase_t     phase_q;  // latched copies below
    logic       psw_n_q;
    logic       psw_z_q;
    logic       psw_v_q;
    logic       psw_c_q;

    isr_field_decode u_field (
        .clk(clk), .arst_n(arst_n), .isr_valid(isr_valid), .isr(isr),
        .phase_in(phase), .psw_n_in(psw_n), .psw_z_in(psw_z),
        .psw_v_in(psw_v), .psw_c_in(psw_c), .ctl_valid(ctl_valid),
        .op(op), .f_mode(f_mode), .t_mode(t_mode), .f_reg(f_reg), .t_reg(t_reg),
        .phase(phase_q), .psw_n(psw_n_q), .psw_z(psw_z_q),
        .psw_v(psw_v_q), .psw_c(psw_c_q)
    );

    reg_port_decode u_reg (
        .op(op), .f_mode(f_mode), .t_mode(t_mode), .f_reg(f_reg), .t_reg(t_reg),
        .phase(phase_q), .psw_n(psw_n_q), .psw_z(psw_z_q), .psw_v(psw_v_q),
        .psw_c(psw_c_q), .r_addr(r_addr), .sr(sr), .f_is_d(f_is_d), .t_is_d(t_is_d)
    );

    alu_ctl_decode u_alu (
        .op(op), .f_mode(f_mode), .phase(phase_q), .psw_c(psw_c_q),
        .alu_x(alu_x), .alu_y(alu_y), .alu_z(alu_z), .alu_u(alu_u), .alu_v(alu_v),
        .shs(shs), .sft_a(sft_a), .sft_b(sft_b), .sft_c(sft_c), .sft_d(sft_d),
        .sft_e(sft_e), .sft_r(sft_r), .sft_l(sft_l), .set_psw(set_psw)
    );

    bus_ctl_decode u_bus (
        .op(op), .phase(phase_q), .mda(mda), .b0b(b0b), .smd(smd),
        .sma(sma), .sb0(sb0), .als(als)
    );

endmodule

/* bus_ctl_decode.sv */
`timescale 1ns/100ps
`include "isr_decoder_defs.svh"

module bus_ctl_decode (
    input  isr_decoder_pkg::ex_op_e op,
    input  isr_decoder_pkg::phase_t phase,
    output logic                    mda,
    output logic                    b0b,
    output logic                    smd,
    output logic                    sma,
    output logic                    sb0,
    output logic                    als
);
    import isr_decoder_pkg::*;

    logic shift_op;
    logic branch_op;
    logic b0b_op;

    assign shift_op  = op inside {OP_ASL, OP_ASR, OP_RLC, OP_RRC,
                                  OP_LSL, OP_LSR, OP_ROL, OP_ROR};
    assign branch_op = op inside {OP_BRN, OP_BRZ, OP_BRV, OP_BRC,
                                  OP_RBN, OP_RBZ, OP_RBV, OP_RBC};

    // two-operand, jump, call and branch ops
    assign b0b_op = branch_op |
                    (op inside {OP_MOV, OP_JMP, OP_ADD, OP_ADC, OP_RJP, OP_SUB, OP_SBC,
                                OP_CMP, OP_OR, OP_XOR, OP_AND, OP_BIT,
                                OP_JSR, OP_RJS, OP_SVC});

    assign mda = phase[`PH_FF2] | shift_op |
                 (op inside {OP_ADD, OP_ADC, OP_RJP, OP_SUB, OP_SBC, OP_CMP,
                             OP_OR, OP_XOR, OP_AND, OP_BIT,
                             OP_RBN, OP_RBZ, OP_RBV, OP_RBC});
    assign b0b = phase[`PH_EX1] | b0b_op;
    assign smd = phase[`PH_IF0] | phase[`PH_FF0] | phase[`PH_TF0] | shift_op |
                 (op inside {OP_CLR, OP_MOV, OP_ADD, OP_ADC, OP_RJP, OP_SUB, OP_SBC,
                             OP_OR, OP_XOR, OP_AND, OP_JSR, OP_RJS, OP_SVC});
    assign sma = phase[`PH_IF0] | phase[`PH_FF0] | phase[`PH_TF0] | phase[`PH_IT0];
    assign sb0 = phase[`PH_FF2];  // byte-zero path in the second from-fetch

    assign als = phase[`PH_IF0] | phase[`PH_IF1] | phase[`PH_FF0] | phase[`PH_FF1] |
                 phase[`PH_FF2] | phase[`PH_TF0] | phase[`PH_TF1] | phase[`PH_EX1] |
                 phase[`PH_IT0] | phase[`PH_IT1] |
                 b0b_op | (op inside {OP_CLR, OP_RET, OP_RIT});

endmodule

/* alu_ctl_decode.sv */
`timescale 1ns/100ps
`include "isr_decoder_defs.svh"

module alu_ctl_decode (
    input  isr_decoder_pkg::ex_op_e     op,
    input  isr_decoder_pkg::addr_mode_e f_mode,
    input  isr_decoder_pkg::phase_t     phase,
    input  logic                        psw_c,
    output logic                        alu_x,
    output logic                        alu_y,
    output logic                        alu_z,
    output logic                        alu_u,
    output logic                        alu_v,
    output logic                        shs,
    output logic                        sft_a,
    output logic                        sft_b,
    output logic                        sft_c,
    output logic                        sft_d,
    output logic                        sft_e,
    output logic                        sft_r,
    output logic                        sft_l,
    output logic                        set_psw
);
    import isr_decoder_pkg::*;

    logic shift_op;
    logic br_op;
    logic rb_op;
    logic ph_y;

    assign shift_op = op inside {OP_ASL, OP_ASR, OP_RLC, OP_RRC,
                                 OP_LSL, OP_LSR, OP_ROL, OP_ROR};
    assign br_op    = op inside {OP_BRN, OP_BRZ, OP_BRV, OP_BRC};
    assign rb_op    = op inside {OP_RBN, OP_RBZ, OP_RBV, OP_RBC};

    // address and operand phases that pass through the ALU
    assign ph_y = phase[`PH_IF0] | phase[`PH_IF1] | phase[`PH_FF0] | phase[`PH_FF2] |
                  phase[`PH_TF0] | phase[`PH_TF1] | phase[`PH_EX1] |
                  phase[`PH_IT0] | phase[`PH_IT1];

    assign alu_x = (phase[`PH_FF0] & (f_mode == MODE_MI)) |
                   (op inside {OP_SUB, OP_SBC, OP_CMP});
    assign alu_y = ph_y | br_op |
                   (op inside {OP_MOV, OP_JMP, OP_RET, OP_RIT, OP_ADD, OP_ADC, OP_RJP,
                               OP_SUB, OP_SBC, OP_CMP, OP_JSR, OP_RJS, OP_SVC});
    assign alu_z = (op == OP_OR) | rb_op;
    assign alu_u = phase[`PH_IF1] | phase[`PH_TF1] | phase[`PH_IT1] |
                   (op inside {OP_SUB, OP_CMP}) |
                   (psw_c & (op inside {OP_ADC, OP_SBC})); // carry in
    assign alu_v = alu_y | (op == OP_XOR) | rb_op;

    assign shs   = shift_op;
    assign sft_a = (op == OP_ASR);
    assign sft_b = (op == OP_ROL);
    assign sft_c = op inside {OP_LSR, OP_ROL, OP_RLC};
    assign sft_d = (op == OP_ROR);
    assign sft_e = op inside {OP_RLC, OP_RRC};
    assign sft_r = op inside {OP_ASR, OP_ROR, OP_RRC};
    assign sft_l = op inside {OP_ASR, OP_LSR, OP_ROL, OP_RLC};

    assign set_psw = shift_op |
                     (op inside {OP_CLR, OP_MOV, OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CMP,
                                 OP_OR, OP_XOR, OP_AND, OP_BIT});

endmodule

/* reg_port_decode.sv */
`timescale 1ns/100ps
`include "isr_decoder_defs.svh"

module reg_port_decode (
    input  isr_decoder_pkg::ex_op_e     op,
    input  isr_decoder_pkg::addr_mode_e f_mode,
    input  isr_decoder_pkg::addr_mode_e t_mode,
    input  isr_decoder_pkg::reg_sel_t   f_reg,
    input  isr_decoder_pkg::reg_sel_t   t_reg,
    input  isr_decoder_pkg::phase_t     phase,
    input  logic                        psw_n,
    input  logic                        psw_z,
    input  logic                        psw_v,
    input  logic                        psw_c,
    output isr_decoder_pkg::reg_sel_t   r_addr,
    output isr_decoder_pkg::reg_sel_t   sr,
    output logic                        f_is_d,
    output logic                        t_is_d
);
    import isr_decoder_pkg::*;

    logic f_ip;
    logic t_ip;
    logic rd_f;
    logic rd_t;
    logic wr_f;
    logic wr_t;
    logic wb_op;
    logic br_taken;
    logic call_ex;

    assign f_is_d = (f_mode == MODE_D);
    assign t_is_d = (t_mode == MODE_D);
    assign f_ip   = (f_mode == MODE_IP);
    assign t_ip   = (t_mode == MODE_IP);

    // result goes back to a direct destination register
    assign wb_op = op inside {OP_CLR, OP_ASL, OP_ASR, OP_RLC, OP_RRC, OP_LSL, OP_LSR,
                              OP_ROL, OP_ROR, OP_MOV, OP_ADD, OP_ADC, OP_RJP,
                              OP_OR, OP_XOR, OP_AND};

    // BRx and RBx share one flag each
    assign br_taken = (psw_n & (op inside {OP_BRN, OP_RBN})) |
                      (psw_z & (op inside {OP_BRZ, OP_RBZ})) |
                      (psw_v & (op inside {OP_BRV, OP_RBV})) |
                      (psw_c & (op inside {OP_BRC, OP_RBC}));

    assign call_ex = phase[`PH_EX1] & (op inside {OP_JSR, OP_RJS, OP_SVC});

    assign rd_f = phase[`PH_FF0] | (phase[`PH_FF1] & f_ip);
    assign rd_t = phase[`PH_TF0] | (phase[`PH_TF1] & t_ip);
    assign wr_f = rd_f;                                      // same operand terms on write
    assign wr_t = (phase[`PH_TF1] & t_ip) | (wb_op & t_is_d); // no TF0 write

    always_comb begin
        r_addr = ({`NUM_REGS{rd_f}} & f_reg) | ({`NUM_REGS{rd_t}} & t_reg);
        r_addr[`SP_REG] = r_addr[`SP_REG] | (op inside {OP_RET, OP_RIT}) |
                          phase[`PH_IT0] | phase[`PH_IT1];
        r_addr[`PC_REG] = r_addr[`PC_REG] | phase[`PH_IF0] | phase[`PH_IF1] |
                          ((op == OP_RJS) & phase[`PH_EX1]);
    end

    always_comb begin
        sr = ({`NUM_REGS{wr_f}} & f_reg) | ({`NUM_REGS{wr_t}} & t_reg);
        sr[`SP_REG] = sr[`SP_REG] | phase[`PH_IT1];
        sr[`PC_REG] = sr[`PC_REG] | phase[`PH_IF1] | phase[`PH_IT2] |
                      (op inside {OP_JMP, OP_RET, OP_RIT}) |
                      br_taken | call_ex;
    end

endmodule

/* isr_field_decode.sv */
`timescale 1ns/100ps
`include "isr_decoder_defs.svh"

module isr_field_decode (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        isr_valid,
    input  isr_decoder_pkg::isr_t       isr,
    input  isr_decoder_pkg::phase_t     phase_in,
    input  logic                        psw_n_in,
    input  logic                        psw_z_in,
    input  logic                        psw_v_in,
    input  logic                        psw_c_in,
    output logic                        ctl_valid,
    output isr_decoder_pkg::ex_op_e     op,
    output isr_decoder_pkg::addr_mode_e f_mode,
    output isr_decoder_pkg::addr_mode_e t_mode,
    output isr_decoder_pkg::reg_sel_t   f_reg,
    output isr_decoder_pkg::reg_sel_t   t_reg,
    output isr_decoder_pkg::phase_t     phase,
    output logic                        psw_n,
    output logic                        psw_z,
    output logic                        psw_v,
    output logic                        psw_c
);
    import isr_decoder_pkg::*;

    isr_t              isr_q;
    logic [`REG_W-1:0] f_idx;
    logic [`REG_W-1:0] t_idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctl_valid <= 1'b0;
            isr_q     <= '0;
            phase     <= '0;
            psw_n     <= 1'b0;
            psw_z     <= 1'b0;
            psw_v     <= 1'b0;
            psw_c     <= 1'b0;
        end else begin
            ctl_valid <= isr_valid; // one cycle per strobe
            if (isr_valid) begin
                isr_q <= isr;
                phase <= phase_in;
                psw_n <= psw_n_in;
                psw_z <= psw_z_in;
                psw_v <= psw_v_in;
                psw_c <= psw_c_in;
            end
        end
    end

    assign op     = ex_op_e'(isr_q[`OP_LSB +: `OP_W]);
    assign f_mode = addr_mode_e'(isr_q[`F_MODE_LSB +: `MODE_W]);
    assign t_mode = addr_mode_e'(isr_q[`T_MODE_LSB +: `MODE_W]);
    assign f_idx  = isr_q[`F_REG_LSB +: `REG_W];
    assign t_idx  = isr_q[`T_REG_LSB +: `REG_W];

    // register fields as one-hot selects
    assign f_reg = reg_sel_t'(1) << f_idx;
    assign t_reg = reg_sel_t'(1) << t_idx;

endmodule

/* isr_decoder_pkg.sv */
`include "isr_decoder_defs.svh"

package isr_decoder_pkg;

    typedef logic [`ISR_W-1:0]    isr_t;
    typedef logic [`PH_IT2:0]     phase_t;   // one bit per phase
    typedef logic [`NUM_REGS-1:0] reg_sel_t; // bit n is register n

    typedef enum logic [`MODE_W-1:0] {
        MODE_D  = 2'd0, // direct
        MODE_I  = 2'd1, // indirect
        MODE_MI = 2'd2, // pre-decrement
        MODE_IP = 2'd3  // post-increment
    } addr_mode_e;

    // codes not listed here raise no operation term
    typedef enum logic [`OP_W-1:0] {
        OP_CLR = 6'b000100,
        OP_ASL = 6'b001000,
        OP_ASR = 6'b001001,
        OP_RLC = 6'b001010,
        OP_RRC = 6'b001011,
        OP_LSL = 6'b001100,
        OP_LSR = 6'b001101,
        OP_ROL = 6'b001110,
        OP_ROR = 6'b001111,
        OP_MOV = 6'b010000,
        OP_JMP = 6'b010001,
        OP_RET = 6'b010010,
        OP_RIT = 6'b010011,
        OP_ADD = 6'b010100,
        OP_RJP = 6'b010101,
        OP_ADC = 6'b010110,
        OP_SUB = 6'b011000,
        OP_SBC = 6'b011010,
        OP_CMP = 6'b011011,
        OP_OR  = 6'b100000,
        OP_XOR = 6'b100001,
        OP_AND = 6'b100010,
        OP_BIT = 6'b100011,
        OP_JSR = 6'b101100,
        OP_RJS = 6'b101101,
        OP_SVC = 6'b101110,
        OP_BRN = 6'b110000,
        OP_BRZ = 6'b110001,
        OP_BRV = 6'b110010,
        OP_BRC = 6'b110011,
        OP_RBN = 6'b111000,
        OP_RBZ = 6'b111001,
        OP_RBV = 6'b111010,
        OP_RBC = 6'b111011
    } ex_op_e;

endpackage

/* isr_decoder_defs.svh */
`ifndef ISR_DECODER_DEFS_SVH
`define ISR_DECODER_DEFS_SVH

// instruction-state word layout
`define ISR_W       16
`define OP_W        6
`define MODE_W      2
`define REG_W       3
`define OP_LSB      10
`define F_MODE_LSB  8
`define F_REG_LSB   5
`define T_MODE_LSB  3
`define T_REG_LSB   0

`define NUM_REGS    8
`define PC_REG      7
`define SP_REG      6

// bit index of each timing phase
`define PH_IF0      0
`define PH_IF1      1
`define PH_FF0      2
`define PH_FF1      3
`define PH_FF2      4
`define PH_TF0      5
`define PH_TF1      6
`define PH_EX1      7
`define PH_IT0      8
`define PH_IT1      9
`define PH_IT2      10

`endif
